/* source/crate_bridge_pkg.sv */
package crate_bridge_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    // TURFIO links behind the bridge
    localparam int NUM_LINKS     = 4;
    localparam int LINK_W        = 2;
    // Host register space
    localparam int ADDR_W        = 16;
    localparam int DATA_W        = 32;
    // Set means crate space, clear means local
    localparam int CRATE_SEL_BIT = 15;

    ////////////////////////////////////////
    // Local address map
    ////////////////////////////////////////

    localparam logic [ADDR_W-1:0] ADDR_IDENT       = 16'h0000;
    localparam logic [ADDR_W-1:0] ADDR_DATEVERSION = 16'h0004;
    localparam logic [ADDR_W-1:0] ADDR_BRIDGE_CTRL = 16'h0008;
    localparam logic [ADDR_W-1:0] ADDR_STATUS      = 16'h000C;

    // ASCII "TURF"
    localparam logic [DATA_W-1:0] IDENT_WORD = 32'h54555246;
    // Read data on any error response
    localparam logic [DATA_W-1:0] BAD_DATA   = 32'hBADACCE5;

    ////////////////////////////////////////
    // Bus beats
    ////////////////////////////////////////

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              write;
        logic [DATA_W-1:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
    } host_rsp_t;

    // Crate address drops the select bit
    typedef struct packed {
        logic [LINK_W-1:0]        link;
        logic                     write;
        logic [CRATE_SEL_BIT-1:0] addr;
        logic [DATA_W-1:0]        wdata;
    } link_cmd_t;

    typedef struct packed {
        logic [LINK_W-1:0] link;
        logic [DATA_W-1:0] rdata;
    } link_rsp_t;

    typedef struct packed {
        logic              enable;
        logic [LINK_W-1:0] link;
    } bridge_cfg_t;

endpackage

/* source/bridge_timer.sv */
`timescale 1ns/10ps
module bridge_timer #(
    parameter int TIMEOUT_CYCLES = 64
) (
    input  logic ps_clk,
    input  logic rst_n_i,
    input  logic start_i,
    input  logic stop_i,
    output logic expired_o
);

    // Wide enough to hold the limit itself
    localparam int              CNT_W   = $clog2(TIMEOUT_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(TIMEOUT_CYCLES);

    logic             running;
    logic [CNT_W-1:0] count;

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            running <= 1'b0;
            count   <= '0;
        end else if (stop_i) begin
            running <= 1'b0;
            count   <= '0;
        end else if (start_i) begin
            running <= 1'b1;
            count   <= '0;
        end else if (running && (count != CNT_MAX)) begin
            // Saturates at the limit
            count <= count + 1'b1;
        end
    end

    assign expired_o = running && (count == CNT_MAX);

    // Limit reached means the owner stops the count in the same cycle
    expiry_stop_a : assert property (
        @(posedge ps_clk) disable iff (!rst_n_i) expired_o |-> stop_i
    );

endmodule

/* source/id_ctrl_regs.sv */
`timescale 1ns/10ps
module id_ctrl_regs #(
    parameter logic [31:0] DATEVERSION = 32'h0002_0018
) (
    input  logic                                   ps_clk,
    input  logic                                   rst_n_i,
    input  logic                                   strobe_i,
    input  crate_bridge_pkg::host_req_t            req_i,
    output logic [crate_bridge_pkg::DATA_W-1:0]    rdata_o,
    output crate_bridge_pkg::bridge_cfg_t          cfg_o,
    input  logic [crate_bridge_pkg::NUM_LINKS-1:0] link_up_i,
    input  logic                                   timeout_pulse_i,
    input  logic                                   invalid_pulse_i
);

    crate_bridge_pkg::bridge_cfg_t cfg_q;
    // Sticky error flags
    logic timeout_flag;
    logic invalid_flag;

    logic ctrl_wr;
    logic status_wr;

    assign ctrl_wr   = strobe_i && req_i.write &&
                       (req_i.addr == crate_bridge_pkg::ADDR_BRIDGE_CTRL);
    assign status_wr = strobe_i && req_i.write &&
                       (req_i.addr == crate_bridge_pkg::ADDR_STATUS);

    ////////////////////////////////////////
    // Bridge control
    ////////////////////////////////////////

    // Enable in bit 2, link select in 1:0
    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_q <= '0;
        end else if (ctrl_wr) begin
            cfg_q.enable <= req_i.wdata[2];
            cfg_q.link   <= req_i.wdata[1:0];
        end
    end

    assign cfg_o = cfg_q;

    ////////////////////////////////////////
    // Status
    ////////////////////////////////////////

    // New event beats a write-1-to-clear
    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            timeout_flag <= 1'b0;
            invalid_flag <= 1'b0;
        end else begin
            if (timeout_pulse_i) begin
                timeout_flag <= 1'b1;
            end else if (status_wr && req_i.wdata[0]) begin
                timeout_flag <= 1'b0;
            end
            if (invalid_pulse_i) begin
                invalid_flag <= 1'b1;
            end else if (status_wr && req_i.wdata[1]) begin
                invalid_flag <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////

    always_comb begin
        case (req_i.addr)
            crate_bridge_pkg::ADDR_IDENT:       rdata_o = crate_bridge_pkg::IDENT_WORD;
            crate_bridge_pkg::ADDR_DATEVERSION: rdata_o = DATEVERSION;
            crate_bridge_pkg::ADDR_BRIDGE_CTRL: rdata_o = {29'd0, cfg_q.enable, cfg_q.link};
            // Live link state in 7:4
            crate_bridge_pkg::ADDR_STATUS: begin
                rdata_o = {24'd0, link_up_i, 2'b00, invalid_flag, timeout_flag};
            end
            // Unmapped reads zero
            default:                            rdata_o = '0;
        endcase
    end

endmodule

/* source/bridge_fsm.sv */
`timescale 1ns/10ps
module bridge_fsm (
    input  logic                                   ps_clk,
    input  logic                                   rst_n_i,
    input  logic                                   host_req_valid_i,
    input  crate_bridge_pkg::host_req_t            host_req_i,
    output logic                                   host_req_ready_o,
    output logic                                   host_rsp_valid_o,
    output crate_bridge_pkg::host_rsp_t            host_rsp_o,
    input  logic                                   host_rsp_ready_i,
    output logic                                   link_cmd_valid_o,
    output crate_bridge_pkg::link_cmd_t            link_cmd_o,
    input  logic                                   link_cmd_ready_i,
    input  logic                                   link_rsp_valid_i,
    input  crate_bridge_pkg::link_rsp_t            link_rsp_i,
    output logic                                   link_rsp_ready_o,
    input  logic [crate_bridge_pkg::NUM_LINKS-1:0] link_up_i,
    input  crate_bridge_pkg::bridge_cfg_t          cfg_i,
    output logic                                   local_strobe_o,
    output crate_bridge_pkg::host_req_t            local_req_o,
    input  logic [crate_bridge_pkg::DATA_W-1:0]    local_rdata_i,
    output logic                                   tmr_start_o,
    output logic                                   tmr_stop_o,
    input  logic                                   tmr_expired_i,
    output logic                                   timeout_pulse_o,
    output logic                                   invalid_pulse_o
);

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_RESPOND  = 2'd1;
    localparam logic [1:0] ST_SEND_CMD = 2'd2;
    localparam logic [1:0] ST_WAIT_RSP = 2'd3;

    logic [1:0]                  state;
    crate_bridge_pkg::host_rsp_t rsp_q;
    crate_bridge_pkg::link_cmd_t cmd_q;

    logic accept;
    logic is_crate;
    logic link_ok;
    logic rsp_match;

    ////////////////////////////////////////
    // Request decode
    ////////////////////////////////////////

    // Only idle takes a new request
    assign host_req_ready_o = (state == ST_IDLE);
    assign accept           = host_req_valid_i && host_req_ready_o;
    assign is_crate         = host_req_i.addr[crate_bridge_pkg::CRATE_SEL_BIT];
    // Enabled bridge and selected link up
    assign link_ok          = cfg_i.enable && link_up_i[cfg_i.link];

    // Local block sees the raw request
    assign local_strobe_o   = accept && !is_crate;
    assign local_req_o      = host_req_i;
    assign invalid_pulse_o  = accept && is_crate && !link_ok;

    ////////////////////////////////////////
    // Link side
    ////////////////////////////////////////

    // Responses never stall, strays just drop
    assign link_rsp_ready_o = 1'b1;
    assign rsp_match        = link_rsp_valid_i && link_rsp_ready_o &&
                              (link_rsp_i.link == cmd_q.link);

    assign link_cmd_valid_o = (state == ST_SEND_CMD);
    assign link_cmd_o       = cmd_q;
    // Timer runs from command transfer
    assign tmr_start_o      = (state == ST_SEND_CMD) && link_cmd_ready_i;
    assign tmr_stop_o       = (state == ST_WAIT_RSP) && (rsp_match || tmr_expired_i);
    // Matching response wins over expiry
    assign timeout_pulse_o  = (state == ST_WAIT_RSP) && !rsp_match && tmr_expired_i;

    assign host_rsp_valid_o = (state == ST_RESPOND);
    assign host_rsp_o       = rsp_q;

    ////////////////////////////////////////
    // State
    ////////////////////////////////////////

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= (is_crate && link_ok) ? ST_SEND_CMD : ST_RESPOND;
                    end
                end
                ST_SEND_CMD: begin
                    if (link_cmd_ready_i) begin
                        state <= ST_WAIT_RSP;
                    end
                end
                ST_WAIT_RSP: begin
                    if (rsp_match || tmr_expired_i) begin
                        state <= ST_RESPOND;
                    end
                end
                default: begin
                    // Held here under host back-pressure
                    if (host_rsp_ready_i) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Payload, only loaded on state entry
    always_ff @(posedge ps_clk) begin
        if (accept && !is_crate) begin
            rsp_q <= '{rdata: local_rdata_i, err: 1'b0};
        end else if (accept && !link_ok) begin
            rsp_q <= '{rdata: crate_bridge_pkg::BAD_DATA, err: 1'b1};
        end else if (accept) begin
            cmd_q <= '{link:  cfg_i.link,
                       write: host_req_i.write,
                       addr:  host_req_i.addr[crate_bridge_pkg::CRATE_SEL_BIT-1:0],
                       wdata: host_req_i.wdata};
        end else if ((state == ST_WAIT_RSP) && rsp_match) begin
            rsp_q <= '{rdata: link_rsp_i.rdata, err: 1'b0};
        end else if ((state == ST_WAIT_RSP) && tmr_expired_i) begin
            rsp_q <= '{rdata: crate_bridge_pkg::BAD_DATA, err: 1'b1};
        end
    end

    ////////////////////////////////////////
    // Handshake checks
    ////////////////////////////////////////

    // Command beat frozen until taken
    cmd_stable_a : assert property (
        @(posedge ps_clk) disable iff (!rst_n_i)
        link_cmd_valid_o && !link_cmd_ready_i |=> link_cmd_valid_o && $stable(link_cmd_o)
    );

    // Host response frozen until taken
    rsp_stable_a : assert property (
        @(posedge ps_clk) disable iff (!rst_n_i)
        host_rsp_valid_o && !host_rsp_ready_i |=> host_rsp_valid_o && $stable(host_rsp_o)
    );

endmodule

/* source/crate_bridge_top.sv */
`timescale 1ns/10ps
module crate_bridge_top #(
    parameter int          TIMEOUT_CYCLES = 64,
    parameter logic [31:0] DATEVERSION    = 32'h0002_0018
) (
    input  logic                                      ps_clk,
    input  logic                                      rst_n_i,
    // Host side
    input  logic                                      host_req_valid_i,
    input  crate_bridge_pkg::host_req_t               host_req_i,
    output logic                                      host_req_ready_o,
    output logic                                      host_rsp_valid_o,
    output crate_bridge_pkg::host_rsp_t               host_rsp_o,
    input  logic                                      host_rsp_ready_i,
    // TURFIO link side
    output logic                                      link_cmd_valid_o,
    output crate_bridge_pkg::link_cmd_t               link_cmd_o,
    input  logic                                      link_cmd_ready_i,
    input  logic                                      link_rsp_valid_i,
    input  crate_bridge_pkg::link_rsp_t               link_rsp_i,
    output logic                                      link_rsp_ready_o,
    input  logic [crate_bridge_pkg::NUM_LINKS-1:0]    link_up_i
);

    ////////////////////////////////////////
    // Internal wiring
    ////////////////////////////////////////

    // Bridge control from register block
    crate_bridge_pkg::bridge_cfg_t       cfg;
    // Local register access
    logic                                local_strobe;
    crate_bridge_pkg::host_req_t         local_req;
    logic [crate_bridge_pkg::DATA_W-1:0] local_rdata;
    // Timeout counter control
    logic                                tmr_start;
    logic                                tmr_stop;
    logic                                tmr_expired;
    // Sticky flag events
    logic                                timeout_pulse;
    logic                                invalid_pulse;

    // Request routing and link handshake
    bridge_fsm u_fsm (
        .ps_clk           (ps_clk),
        .rst_n_i          (rst_n_i),
        .host_req_valid_i (host_req_valid_i),
        .host_req_i       (host_req_i),
        .host_req_ready_o (host_req_ready_o),
        .host_rsp_valid_o (host_rsp_valid_o),
        .host_rsp_o       (host_rsp_o),
        .host_rsp_ready_i (host_rsp_ready_i),
        .link_cmd_valid_o (link_cmd_valid_o),
        .link_cmd_o       (link_cmd_o),
        .link_cmd_ready_i (link_cmd_ready_i),
        .link_rsp_valid_i (link_rsp_valid_i),
        .link_rsp_i       (link_rsp_i),
        .link_rsp_ready_o (link_rsp_ready_o),
        .link_up_i        (link_up_i),
        .cfg_i            (cfg),
        .local_strobe_o   (local_strobe),
        .local_req_o      (local_req),
        .local_rdata_i    (local_rdata),
        .tmr_start_o      (tmr_start),
        .tmr_stop_o       (tmr_stop),
        .tmr_expired_i    (tmr_expired),
        .timeout_pulse_o  (timeout_pulse),
        .invalid_pulse_o  (invalid_pulse)
    );

    // Link response watchdog
    bridge_timer #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_timer (
        .ps_clk    (ps_clk),
        .rst_n_i   (rst_n_i),
        .start_i   (tmr_start),
        .stop_i    (tmr_stop),
        .expired_o (tmr_expired)
    );

    // ID, version, control and status
    id_ctrl_regs #(.DATEVERSION(DATEVERSION)) u_idctrl (
        .ps_clk          (ps_clk),
        .rst_n_i         (rst_n_i),
        .strobe_i        (local_strobe),
        .req_i           (local_req),
        .rdata_o         (local_rdata),
        .cfg_o           (cfg),
        .link_up_i       (link_up_i),
        .timeout_pulse_i (timeout_pulse),
        .invalid_pulse_i (invalid_pulse)
    );

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/10ps
module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic ps_clk,
    output logic rst_n_o
);

    // Free running clock
    initial begin
        ps_clk = 1'b0;
    end

    always #(PERIOD_NS / 2) ps_clk = ~ps_clk;

    // Reset low from time zero, released on a rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge ps_clk);
        rst_n_o <= 1'b1;
    end

endmodule

/* verif/crate_bridge_tb.sv */
`timescale 1ns/10ps
module crate_bridge_tb;

    localparam int MAX_CASES      = 32;
    localparam int CASE_WORDS     = 8;
    localparam int RST_WAIT_LIMIT = 100;
    localparam int REQ_WAIT_LIMIT = 50;
    localparam int RSP_WAIT_LIMIT = 400;
    localparam int LINK_HOLD_MAX  = 50;

    logic ps_clk;
    logic rst_n;

    // DUT inputs start from known values
    logic                                   host_req_valid_i = 1'b0;
    crate_bridge_pkg::host_req_t            host_req_i       = '0;
    logic                                   host_rsp_ready_i = 1'b0;
    logic                                   link_cmd_ready_i = 1'b0;
    logic                                   link_rsp_valid_i = 1'b0;
    crate_bridge_pkg::link_rsp_t            link_rsp_i       = '0;
    logic [crate_bridge_pkg::NUM_LINKS-1:0] link_up_i        = '0;

    // DUT outputs
    logic                                   host_req_ready_o;
    logic                                   host_rsp_valid_o;
    crate_bridge_pkg::host_rsp_t            host_rsp_o;
    logic                                   link_cmd_valid_o;
    crate_bridge_pkg::link_cmd_t            link_cmd_o;
    logic                                   link_rsp_ready_o;

    // Eight words per case
    logic [31:0] case_mem [0:MAX_CASES*CASE_WORDS-1];

    // Expected command fields for the running case
    logic [crate_bridge_pkg::LINK_W-1:0]        exp_link;
    logic                                       exp_write;
    logic [crate_bridge_pkg::CRATE_SEL_BIT-1:0] exp_addr;
    logic [31:0]                                exp_wdata;
    logic [31:0]                                rsp_delay;
    logic [31:0]                                rsp_word;

    // Bridge control as the host wrote it
    logic                                cfg_enable = 1'b0;
    logic [crate_bridge_pkg::LINK_W-1:0] cfg_link   = '0;

    // Link model state
    int                                  cmd_count     = 0;
    logic                                rsp_pending   = 1'b0;
    logic [31:0]                         rsp_countdown = '0;
    int                                  rsp_hold      = 0;
    logic [crate_bridge_pkg::LINK_W-1:0] cmd_link_q    = '0;

    logic [31:0] lfsr_state = 32'h21c9;
    int          error_count = 0;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(16)) u_clk (
        .ps_clk  (ps_clk),
        .rst_n_o (rst_n)
    );

    crate_bridge_top i_dut (
        .ps_clk           (ps_clk),
        .rst_n_i          (rst_n),
        .host_req_valid_i (host_req_valid_i),
        .host_req_i       (host_req_i),
        .host_req_ready_o (host_req_ready_o),
        .host_rsp_valid_o (host_rsp_valid_o),
        .host_rsp_o       (host_rsp_o),
        .host_rsp_ready_i (host_rsp_ready_i),
        .link_cmd_valid_o (link_cmd_valid_o),
        .link_cmd_o       (link_cmd_o),
        .link_cmd_ready_i (link_cmd_ready_i),
        .link_rsp_valid_i (link_rsp_valid_i),
        .link_rsp_i       (link_rsp_i),
        .link_rsp_ready_o (link_rsp_ready_o),
        .link_up_i        (link_up_i)
    );

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // 32 bit Fibonacci with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("FAILED at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("Simulation failed");
        $fatal(1, "wait limit exceeded");
    endtask

    ////////////////////////////////////////
    // Random back-pressure
    ////////////////////////////////////////

    // One LFSR step per ready bit
    always @(posedge ps_clk) begin
        lfsr_state = lfsr_next(lfsr_state);
        link_cmd_ready_i <= lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        host_rsp_ready_i <= lfsr_state[0];
    end

    ////////////////////////////////////////
    // Link model
    ////////////////////////////////////////

    always @(posedge ps_clk) begin
        // Response beat held until taken
        if (link_rsp_valid_i) begin
            if (link_rsp_ready_o) begin
                link_rsp_valid_i <= 1'b0;
            end else begin
                rsp_hold = rsp_hold + 1;
                if (rsp_hold > LINK_HOLD_MAX) begin
                    report_timeout("link response ready");
                end
            end
        end else if (rsp_pending) begin
            rsp_countdown = rsp_countdown - 1;
            if (rsp_countdown == 0) begin
                link_rsp_valid_i <= 1'b1;
                link_rsp_i       <= '{link: cmd_link_q, rdata: rsp_word};
                rsp_pending = 1'b0;
                rsp_hold    = 0;
            end
        end
        // Command beat taken on this edge
        if (link_cmd_valid_o && link_cmd_ready_i) begin
            cmd_count = cmd_count + 1;
            compare_value(32'(link_cmd_o.link), 32'(exp_link), "command link");
            compare_value(32'(link_cmd_o.write), 32'(exp_write), "command write flag");
            compare_value(32'(link_cmd_o.addr), 32'(exp_addr), "command address");
            if (exp_write) begin
                compare_value(link_cmd_o.wdata, exp_wdata, "command write data");
            end
            cmd_link_q = link_cmd_o.link;
            // Zero delay means a silent link
            if (rsp_delay != 0) begin
                rsp_pending   = 1'b1;
                rsp_countdown = rsp_delay;
            end
        end
    end

    ////////////////////////////////////////
    // Case runner
    ////////////////////////////////////////

    task automatic run_case(input int idx);
        int                                  base;
        logic [3:0]                          up;
        logic                                wr;
        logic [15:0]                         addr;
        logic [31:0]                         wdata;
        logic [31:0]                         exp_rdata;
        logic                                exp_err;
        logic                                expect_cmd;
        int                                  cmd_before;
        int                                  waited;
        logic                                done;
        crate_bridge_pkg::host_rsp_t         got;

        base      = idx * CASE_WORDS;
        up        = case_mem[base][3:0];
        wr        = case_mem[base+1][0];
        addr      = case_mem[base+2][15:0];
        wdata     = case_mem[base+3];
        exp_rdata = case_mem[base+6];
        exp_err   = case_mem[base+7][0];

        // Command only for crate space on an enabled, up link
        expect_cmd = addr[crate_bridge_pkg::CRATE_SEL_BIT] && cfg_enable && up[cfg_link];
        exp_link   = cfg_link;
        exp_write  = wr;
        exp_addr   = addr[crate_bridge_pkg::CRATE_SEL_BIT-1:0];
        exp_wdata  = wdata;
        rsp_delay  = case_mem[base+4];
        rsp_word   = case_mem[base+5];
        cmd_before = cmd_count;

        @(posedge ps_clk);
        link_up_i        <= up;
        host_req_valid_i <= 1'b1;
        host_req_i       <= '{addr: addr, write: wr, wdata: wdata};

        // Request handshake
        done   = 1'b0;
        waited = 0;
        while (!done) begin
            @(posedge ps_clk);
            done   = host_req_ready_o;
            waited = waited + 1;
            if (!done && waited > REQ_WAIT_LIMIT) begin
                report_timeout($sformatf("request acceptance in case %0d", idx));
            end
        end
        host_req_valid_i <= 1'b0;

        // Response handshake with varying latency
        done   = 1'b0;
        waited = 0;
        while (!done) begin
            @(posedge ps_clk);
            done   = host_rsp_valid_o && host_rsp_ready_i;
            got    = host_rsp_o;
            waited = waited + 1;
            if (!done && waited > RSP_WAIT_LIMIT) begin
                report_timeout($sformatf("host response in case %0d", idx));
            end
        end

        compare_value(32'(got.err), 32'(exp_err), $sformatf("case %0d err", idx));
        // Write data echo carries no meaning
        if (!wr || exp_err) begin
            compare_value(got.rdata, exp_rdata, $sformatf("case %0d rdata", idx));
        end
        compare_value(32'(cmd_count - cmd_before), expect_cmd ? 32'd1 : 32'd0,
                      $sformatf("case %0d commands sent", idx));

        // Track the control register
        if (wr && !addr[crate_bridge_pkg::CRATE_SEL_BIT] &&
            addr == crate_bridge_pkg::ADDR_BRIDGE_CTRL) begin
            cfg_enable = wdata[2];
            cfg_link   = wdata[1:0];
        end
    endtask

    initial begin
        int idx;
        int waited;
        logic finished;

        $readmemh("verif/crate_bridge_cases.txt", case_mem);

        // Unknown reset level at time zero counts as still in reset
        waited = 0;
        while (rst_n !== 1'b1) begin
            @(posedge ps_clk);
            waited = waited + 1;
            if (waited > RST_WAIT_LIMIT) begin
                report_timeout("reset release");
            end
        end

        idx      = 0;
        finished = 1'b0;
        while (!finished) begin
            // All ones in the first column ends the list
            if (idx >= MAX_CASES || case_mem[idx*CASE_WORDS] == 32'hFFFF_FFFF) begin
                finished = 1'b1;
            end else begin
                run_case(idx);
                idx = idx + 1;
            end
        end

        repeat (4) @(posedge ps_clk);
        $display("Ran %0d cases", idx);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* src.f */
source/crate_bridge_pkg.sv
source/bridge_timer.sv
source/id_ctrl_regs.sv
source/bridge_fsm.sv
source/crate_bridge_top.sv
verif/tb_clock_gen.sv
verif/crate_bridge_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module crate_bridge_tb \
    -f src.f \
    -o Vcrate_bridge_tb

status=0
./obj_dir/Vcrate_bridge_tb > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "^Simulation passed$" "$LOG"; then
    echo "run_sim: PASS (exit $status)"
    exit 0
fi
echo "run_sim: FAIL (exit $status)"
exit 1

/* verif/crate_bridge_cases.txt */
// Columns: link_up write addr wdata link_delay(0 silent) link_rdata exp_rdata exp_err
// Hex values, one access per line, all ones in column 1 ends the list
0000000f 0 0000 00000000 00 00000000 54555246 0
0000000f 0 0004 00000000 00 00000000 00020018 0
0000000f 0 0008 00000000 00 00000000 00000000 0
0000000f 0 000c 00000000 00 00000000 000000f0 0
0000000f 0 8010 00000000 00 00000000 badacce5 1
0000000f 0 000c 00000000 00 00000000 000000f2 0
0000000f 1 000c 00000003 00 00000000 00000000 0
0000000f 1 0008 00000005 00 00000000 00000000 0
0000000f 0 0008 00000000 00 00000000 00000005 0
0000000f 0 8124 00000000 03 cafe0001 cafe0001 0
0000000f 1 8200 12345678 01 00000000 00000000 0
0000000a 1 0008 00000006 00 00000000 00000000 0
0000000a 0 8040 00000000 02 11111111 badacce5 1
0000000a 0 000c 00000000 00 00000000 000000a2 0
0000000a 1 0008 00000007 00 00000000 00000000 0
0000000a 0 8abc 00000000 05 5a5a0003 5a5a0003 0
0000000a 1 8ab0 a5a5f00d 02 00000000 00000000 0
0000000a 0 8008 00000000 00 00000000 badacce5 1
0000000a 0 000c 00000000 00 00000000 000000a3 0
0000000a 1 000c 00000003 00 00000000 00000000 0
0000000a 0 000c 00000000 00 00000000 000000a0 0
00000005 0 0010 00000000 00 00000000 00000000 0
0000000d 0 fffc 00000000 20 87654321 87654321 0
ffffffff 0 0000 00000000 00 00000000 00000000 0
